/* sources.f */
common/cpu_exec_pkg.sv
rtl/alu/alu_unit.sv
rtl/stack/call_stack_unit.sv
rtl/exec_result_merge.sv
rtl/exec_stage.sv
tb/exec_stage_props.sv
tb/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_exec_stage -o tb_sim --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0

/* tb/tb_exec_stage.sv */
/*
 * testbench for exec_stage: clock, reset, data memory model,
 * reference expectations, stimulus and checking assertions
 */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage;

    localparam logic [3:0] STACK_BASE = 4'd1;

    logic clk;
    logic reset_;
    logic execute_en;
    logic latch_ret_addr;
    cpu_exec_pkg::exec_op_e exec_ctrl;
    cpu_exec_pkg::reg_sel_t dst_reg;
    cpu_exec_pkg::addr_t    dst_addr;
    cpu_exec_pkg::addr_t    next_addr;
    cpu_exec_pkg::data_t    src0_data;
    cpu_exec_pkg::data_t    src1_data;
    cpu_exec_pkg::data_t    mem_rdata;
    cpu_exec_pkg::mem_req_t mem_req;
    cpu_exec_pkg::reg_wr_t  reg_wr;
    cpu_exec_pkg::status_t  status_reg;
    logic                   branch;
    cpu_exec_pkg::addr_t    ret_addr;
    logic                   ret_addr_en;

    cpu_exec_pkg::data_t mem [0:4095];     // DUT-facing memory
    cpu_exec_pkg::data_t ref_mem [0:4095]; // expected contents

    // expectations, set on the falling edge
    logic                  chk_wr, chk_mem, chk_ret, exp_branch;
    logic                  exp_rd, exp_wr_op;
    cpu_exec_pkg::reg_wr_t exp_wr;
    cpu_exec_pkg::addr_t   exp_addr, exp_ret;
    cpu_exec_pkg::data_t   exp_wdata;
    cpu_exec_pkg::status_t exp_status;
    logic [7:0]            exp_sp;
    logic [31:0]           rnd;

    exec_stage #(.STACK_BASE(STACK_BASE)) UUT (.*);

    bind exec_stage exec_stage_props u_props (
        .clk(clk), .reset_(reset_), .stage(stage), .busy(busy), .mem_req(mem_req),
        .reg_wr(reg_wr), .status_reg(status_reg), .branch(branch),
        .ret_addr_en(ret_addr_en)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign mem_rdata = mem[mem_req.addr]; // combinational read
    always @(posedge clk) begin
        if (mem_req.wr) mem[mem_req.addr] <= mem_req.wdata;
    end

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    a_reg_wr: assert property (@(posedge clk) disable iff (!reset_)
        (reg_wr.en == chk_wr) && (!chk_wr || reg_wr == exp_wr))
        else report_fail("register write differs from expected");
    a_mem: assert property (@(posedge clk) disable iff (!reset_)
        (mem_req.en == chk_mem) && (!chk_mem || (mem_req.rd == exp_rd &&
        mem_req.wr == exp_wr_op && mem_req.addr == exp_addr &&
        (!exp_wr_op || mem_req.wdata == exp_wdata))))
        else report_fail("memory request differs from expected");
    a_status: assert property (@(posedge clk) disable iff (!reset_)
        status_reg == exp_status) else report_fail("status_reg differs from expected");
    a_branch: assert property (@(posedge clk) disable iff (!reset_)
        branch == exp_branch) else report_fail("branch strobe differs from expected");
    a_ret: assert property (@(posedge clk) disable iff (!reset_)
        (ret_addr_en == chk_ret) && (!chk_ret || ret_addr == exp_ret))
        else report_fail("return address differs from expected");

    // 9-bit result, bit 8 is carry or borrow
    function automatic logic [8:0] alu_ref(input cpu_exec_pkg::exec_op_e op,
                                           input logic [7:0] a, input logic [7:0] b);
        case (op)
            cpu_exec_pkg::OP_ADD: return {(int'(a) + int'(b)) > 255, a + b};
            cpu_exec_pkg::OP_SUB: return {a < b, a - b};
            cpu_exec_pkg::OP_OR:  return {1'b0, a | b};
            cpu_exec_pkg::OP_AND: return {1'b0, a & b};
            default:              return {1'b0, a ^ b};
        endcase
    endfunction

    task automatic go_idle();
        execute_en     = 1'b0;
        latch_ret_addr = 1'b0;
        exec_ctrl      = cpu_exec_pkg::OP_NOP;
        exp_branch     = 1'b0;
    endtask

    task automatic issue(input cpu_exec_pkg::exec_op_e op, input logic [1:0] dst,
                         input logic [11:0] addr);
        execute_en = 1'b1;
        exec_ctrl  = op;
        dst_reg    = dst;
        dst_addr   = addr;
    endtask

    task automatic expect_mem(input logic rd, input logic wr, input logic [11:0] addr,
                              input logic [7:0] d);
        chk_mem   = 1'b1;
        exp_rd    = rd;
        exp_wr_op = wr;
        exp_addr  = addr;
        exp_wdata = d;
    endtask

    task automatic wait_stack_idle();
        int n;
        n = 0;
        while (UUT.busy) begin
            if (n == 8) timeout_fail("call stack to go idle");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic run_alu(input cpu_exec_pkg::exec_op_e op, input logic [1:0] dst,
                           input logic [7:0] a, input logic [7:0] b);
        logic [8:0] r;
        r = alu_ref(op, a, b);
        issue(op, dst, 12'd0);
        @(negedge clk);
        go_idle();
        src0_data = a;
        src1_data = b;
        chk_wr    = 1'b1;
        exp_wr    = {1'b1, dst, r[7:0]};
        @(negedge clk);
        chk_wr     = 1'b0;
        exp_status = {4'd0, r[7:0] == 8'd0, r[7:0] != 8'd0, 1'b0, r[8]};
    endtask

    task automatic mem_write(input logic [11:0] addr, input logic [7:0] d);
        wait_stack_idle();
        issue(cpu_exec_pkg::OP_MEM_WR, 2'd0, addr);
        @(negedge clk);
        go_idle();
        src0_data = d;
        expect_mem(1'b0, 1'b1, addr, d);
        ref_mem[addr] = d;
        @(negedge clk);
        chk_mem = 1'b0;
    endtask

    task automatic mem_read(input logic [11:0] addr, input logic [1:0] dst);
        wait_stack_idle();
        issue(cpu_exec_pkg::OP_MEM_RD, dst, addr);
        @(negedge clk);
        go_idle();
        expect_mem(1'b1, 1'b0, addr, 8'd0);
        chk_wr = 1'b1;
        exp_wr = {1'b1, dst, ref_mem[addr]};
        @(negedge clk);
        chk_mem = 1'b0;
        chk_wr  = 1'b0;
    endtask

    task automatic jump();
        issue(cpu_exec_pkg::OP_JMP, 2'd0, 12'd0);
        exp_branch = 1'b1;
        @(negedge clk);
        go_idle();
        @(negedge clk);
        exp_status = '0; // flow change clears flags
    endtask

    task automatic call(input logic [11:0] na);
        issue(cpu_exec_pkg::OP_CALL, 2'd0, 12'd0);
        latch_ret_addr = 1'b1;
        next_addr      = na;
        exp_branch     = 1'b1;
        @(negedge clk);
        go_idle();
        expect_mem(1'b0, 1'b1, {STACK_BASE, exp_sp}, {4'd0, na[11:8]});
        ref_mem[{STACK_BASE, exp_sp}] = {4'd0, na[11:8]};
        @(negedge clk);
        exp_status = '0;
        expect_mem(1'b0, 1'b1, {STACK_BASE, exp_sp + 8'd1}, na[7:0]);
        ref_mem[{STACK_BASE, exp_sp + 8'd1}] = na[7:0];
        @(negedge clk);
        chk_mem = 1'b0;
        exp_sp  = exp_sp + 8'd2;
    endtask

    task automatic ret(input logic [11:0] expected);
        int n;
        issue(cpu_exec_pkg::OP_RET, 2'd0, 12'd0);
        expect_mem(1'b1, 1'b0, {STACK_BASE, exp_sp - 8'd1}, 8'd0); // low byte first
        @(negedge clk);
        go_idle();
        expect_mem(1'b1, 1'b0, {STACK_BASE, exp_sp - 8'd2}, 8'd0);
        @(negedge clk);
        chk_mem    = 1'b0;
        exp_status = '0;
        chk_ret    = 1'b1;
        exp_ret    = expected;
        n = 0;
        while (!ret_addr_en) begin
            if (n == 4) timeout_fail("ret_addr_en");
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        chk_ret = 1'b0;
        exp_sp  = exp_sp - 8'd2;
    endtask

    initial begin
        logic [11:0] na;
        logic [11:0] nb;
        logic [11:0] wa;
        rnd = $urandom(4);
        for (int i = 0; i < 4096; i++) begin
            mem[i]     = 8'(i) ^ 8'(i >> 4); // varies with every address bit
            ref_mem[i] = mem[i];
        end
        reset_    = 1'b0;
        go_idle();
        dst_reg   = '0;
        dst_addr  = '0;
        next_addr = '0;
        src0_data = '0;
        src1_data = '0;
        {chk_wr, chk_mem, chk_ret, exp_rd, exp_wr_op} = '0;
        exp_wr     = '0;
        exp_addr   = '0;
        exp_ret    = '0;
        exp_wdata  = '0;
        exp_status = '0;
        exp_sp     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_ = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 20; i++) begin
            rnd = $urandom();
            run_alu(cpu_exec_pkg::exec_op_e'(4'(1 + rnd % 5)), rnd[9:8], rnd[23:16],
                    rnd[31:24]);
        end
        run_alu(cpu_exec_pkg::OP_ADD, 2'd1, 8'd200, 8'd100); // carry out
        run_alu(cpu_exec_pkg::OP_SUB, 2'd2, 8'd5, 8'd10);    // borrow
        rnd = $urandom();
        wa  = rnd[11:0];
        mem_write(wa, ~ref_mem[wa]); // flags must hold
        run_alu(cpu_exec_pkg::OP_XOR, 2'd3, 8'h5a, 8'h5a);   // zero result
        mem_read(wa, 2'd2);

        rnd = $urandom();
        na  = rnd[11:0];
        call(na);
        run_alu(cpu_exec_pkg::OP_OR, 2'd0, 8'h0f, 8'h30);    // flags for the jump to clear
        jump();
        rnd = $urandom();
        nb  = rnd[11:0];
        call(nb);                                            // nested call
        ret(nb);
        run_alu(cpu_exec_pkg::OP_AND, 2'd1, 8'hf0, 8'h3c);   // flags for the return to clear
        ret(na);                                             // bytes come back from memory
        rnd = $urandom();
        call(rnd[11:0]); // same stack addresses again
        ret(rnd[11:0]);
        repeat (2) @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/exec_stage_props.sv */
/*
 * protocol assertions for the execute stage top level,
 * bound into exec_stage
 */
`timescale 1ns/1ps
`default_nettype none

module exec_stage_props (
    input wire                       clk,
    input wire                       reset_,
    input cpu_exec_pkg::exec_stage_t stage,
    input wire                       busy,
    input cpu_exec_pkg::mem_req_t    mem_req,
    input cpu_exec_pkg::reg_wr_t     reg_wr,
    input cpu_exec_pkg::status_t     status_reg,
    input wire                       branch,
    input wire                       ret_addr_en
);

    logic stage_mem; // stage holds a load or store

    assign stage_mem = stage.valid && ((stage.op == cpu_exec_pkg::OP_MEM_RD) ||
                                       (stage.op == cpu_exec_pkg::OP_MEM_WR));

    rd_wr_excl: assert property (@(posedge clk) disable iff (!reset_)
        !(mem_req.rd && mem_req.wr))
        else $error("memory read and write high together");

    en_matches: assert property (@(posedge clk) disable iff (!reset_)
        mem_req.en == (mem_req.rd || mem_req.wr))
        else $error("memory enable differs from read or write");

    no_mem_while_busy: assert property (@(posedge clk) disable iff (!reset_)
        !(stage_mem && busy))
        else $error("stage memory operation issued while stack busy");

    ret_en_pulse: assert property (@(posedge clk) disable iff (!reset_)
        ret_addr_en |=> !ret_addr_en)
        else $error("ret_addr_en longer than one cycle");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(reset_) |-> (!mem_req.en && !reg_wr.en && !ret_addr_en && !branch &&
                           !busy && (status_reg == '0)))
        else $error("control outputs not low after reset");

endmodule

`default_nettype wire

/* rtl/exec_stage.sv */
/*
 * execute stage top: operation stage register, branch strobe,
 * ALU, call stack and result merge instances
 */
`timescale 1ns/1ps
`default_nettype none

module exec_stage #(
    parameter logic [3:0] STACK_BASE = 4'd1 // upper stack address bits
) (
    input  wire                     clk,
    input  wire                     reset_,
    input  wire                     execute_en,
    input  cpu_exec_pkg::exec_op_e  exec_ctrl,
    input  cpu_exec_pkg::reg_sel_t  dst_reg,
    input  cpu_exec_pkg::addr_t     dst_addr,
    input  cpu_exec_pkg::data_t     src0_data,
    input  cpu_exec_pkg::data_t     src1_data,
    input  wire                     latch_ret_addr,
    input  cpu_exec_pkg::addr_t     next_addr,
    input  cpu_exec_pkg::data_t     mem_rdata,
    output cpu_exec_pkg::mem_req_t  mem_req,
    output cpu_exec_pkg::reg_wr_t   reg_wr,
    output cpu_exec_pkg::status_t   status_reg,
    output logic                    branch,
    output cpu_exec_pkg::addr_t     ret_addr,
    output logic                    ret_addr_en
);

    cpu_exec_pkg::exec_stage_t stage;     // operation aligned with its operands
    cpu_exec_pkg::reg_wr_t     alu_wr;
    cpu_exec_pkg::mem_req_t    stack_req;
    logic                      busy;

    // operands come one cycle after decode, so hold the operation until then
    always_ff @(posedge clk) begin
        if (!reset_) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= execute_en;
        end
    end

    always_ff @(posedge clk) begin
        stage.op       <= exec_ctrl;
        stage.dst_reg  <= dst_reg;
        stage.dst_addr <= dst_addr;
    end

    assign branch = execute_en &&
                    ((exec_ctrl == cpu_exec_pkg::OP_JMP) ||
                     (exec_ctrl == cpu_exec_pkg::OP_CALL)); // pc redirect, same cycle

    alu_unit u_alu (
        .clk        (clk),
        .reset_     (reset_),
        .stage      (stage),
        .src0_data  (src0_data),
        .src1_data  (src1_data),
        .alu_wr     (alu_wr),
        .status_reg (status_reg)
    );

    call_stack_unit #(
        .STACK_BASE (STACK_BASE)
    ) u_call_stack (
        .clk            (clk),
        .reset_         (reset_),
        .execute_en     (execute_en),
        .exec_ctrl      (exec_ctrl),
        .latch_ret_addr (latch_ret_addr),
        .next_addr      (next_addr),
        .mem_rdata      (mem_rdata),
        .stack_req      (stack_req),
        .busy           (busy),
        .ret_addr       (ret_addr),
        .ret_addr_en    (ret_addr_en)
    );

    exec_result_merge u_merge (
        .stage     (stage),
        .src0_data (src0_data),
        .alu_wr    (alu_wr),
        .stack_req (stack_req),
        .mem_rdata (mem_rdata),
        .busy      (busy),
        .mem_req   (mem_req),
        .reg_wr    (reg_wr)
    );

endmodule

`default_nettype wire

/* rtl/exec_result_merge.sv */
/*
 * memory port arbitration between call stack and stage access,
 * register write-back selection
 */
`timescale 1ns/1ps
`default_nettype none

module exec_result_merge (
    input  cpu_exec_pkg::exec_stage_t stage,
    input  cpu_exec_pkg::data_t       src0_data,
    input  cpu_exec_pkg::reg_wr_t     alu_wr,
    input  cpu_exec_pkg::mem_req_t    stack_req,
    input  cpu_exec_pkg::data_t       mem_rdata,
    input  wire                       busy,
    output cpu_exec_pkg::mem_req_t    mem_req,
    output cpu_exec_pkg::reg_wr_t     reg_wr
);

    logic                   stage_rd;  // stage load
    logic                   stage_wr;  // stage store
    logic                   stage_own; // stage may use the port
    cpu_exec_pkg::mem_req_t stage_req;

    assign stage_rd  = stage.valid && (stage.op == cpu_exec_pkg::OP_MEM_RD);
    assign stage_wr  = stage.valid && (stage.op == cpu_exec_pkg::OP_MEM_WR);
    assign stage_own = !busy;

    // direct address from the stage, store data is src0
    always_comb begin
        stage_req.en    = stage_rd || stage_wr;
        stage_req.rd    = stage_rd;
        stage_req.wr    = stage_wr;
        stage_req.addr  = stage.dst_addr;
        stage_req.wdata = src0_data;
    end

    // call stack wins the port
    always_comb begin
        if (stack_req.en) begin
            mem_req = stack_req;
        end else begin
            mem_req = stage_req;
        end
    end

    // loaded byte, else whatever the ALU produced
    always_comb begin
        if (stage_rd) begin
            reg_wr.en   = stage_own;
            reg_wr.sel  = stage.dst_reg;
            reg_wr.data = mem_rdata;
        end else begin
            reg_wr = alu_wr;
        end
    end

endmodule

`default_nettype wire

/* rtl/stack/call_stack_unit.sv */
/*
 * call/return sequencer: pushes and pops the 12-bit return address
 * as two bytes, stack pointer and return address bytes
 */
`timescale 1ns/1ps
`default_nettype none

module call_stack_unit #(
    parameter logic [3:0] STACK_BASE = 4'd1
) (
    input  wire                     clk,
    input  wire                     reset_,
    input  wire                     execute_en,
    input  cpu_exec_pkg::exec_op_e  exec_ctrl,
    input  wire                     latch_ret_addr,
    input  cpu_exec_pkg::addr_t     next_addr,
    input  cpu_exec_pkg::data_t     mem_rdata,
    output cpu_exec_pkg::mem_req_t  stack_req,
    output logic                    busy,
    output cpu_exec_pkg::addr_t     ret_addr,
    output logic                    ret_addr_en
);

    cpu_exec_pkg::stack_state_e state;
    cpu_exec_pkg::stack_state_e state_nxt;

    logic [7:0]          sp;      // low byte of stack address
    cpu_exec_pkg::data_t ret_hi;  // upper byte, address bits in [3:0]
    cpu_exec_pkg::data_t ret_lo;
    logic                ret_start;
    logic                push;
    logic                pop;

    // lower byte is read in the RET cycle itself
    assign ret_start = execute_en && (exec_ctrl == cpu_exec_pkg::OP_RET) &&
                       (state == cpu_exec_pkg::ST_IDLE);

    assign push = (state == cpu_exec_pkg::ST_PUSH_HI) ||
                  (state == cpu_exec_pkg::ST_PUSH_LO);
    assign pop  = ret_start || (state == cpu_exec_pkg::ST_POP_HI);

    always_comb begin
        state_nxt = state;
        case (state)
            cpu_exec_pkg::ST_IDLE: begin
                if (latch_ret_addr) begin
                    state_nxt = cpu_exec_pkg::ST_PUSH_HI;
                end else if (ret_start) begin
                    state_nxt = cpu_exec_pkg::ST_POP_HI;
                end
            end
            cpu_exec_pkg::ST_PUSH_HI: state_nxt = cpu_exec_pkg::ST_PUSH_LO;
            cpu_exec_pkg::ST_PUSH_LO: state_nxt = cpu_exec_pkg::ST_IDLE;
            cpu_exec_pkg::ST_POP_HI:  state_nxt = cpu_exec_pkg::ST_IDLE;
            default:                  state_nxt = cpu_exec_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            state       <= cpu_exec_pkg::ST_IDLE;
            sp          <= 8'd0;
            ret_addr_en <= 1'b0;
        end else begin
            state       <= state_nxt;
            ret_addr_en <= (state == cpu_exec_pkg::ST_POP_HI); // both bytes in hand
            if (push) begin
                sp <= sp + 8'd1;
            end else if (pop) begin
                sp <= sp - 8'd1;
            end
        end
    end

    // return address bytes, loaded on call or from memory on return
    always_ff @(posedge clk) begin
        if (latch_ret_addr) begin
            ret_hi <= {4'd0, next_addr[11:8]};
            ret_lo <= next_addr[7:0];
        end else begin
            if (ret_start) begin
                ret_lo <= mem_rdata;
            end
            if (state == cpu_exec_pkg::ST_POP_HI) begin
                ret_hi <= mem_rdata;
            end
        end
    end

    assign ret_addr = {ret_hi[3:0], ret_lo};

    // push writes at sp, pop reads at sp-1
    always_comb begin
        stack_req.rd    = pop;
        stack_req.wr    = push;
        stack_req.en    = pop || push;
        stack_req.addr  = push ? {STACK_BASE, sp} : {STACK_BASE, sp - 8'd1};
        stack_req.wdata = (state == cpu_exec_pkg::ST_PUSH_HI) ? ret_hi : ret_lo;
    end

    assign busy = push || pop; // cycles that own the memory port

endmodule

`default_nettype wire

/* rtl/alu/alu_unit.sv */
/*
 * ALU datapath for add, sub, or, and, xor, flag generation
 * and the status register
 */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                       clk,
    input  wire                       reset_,
    input  cpu_exec_pkg::exec_stage_t stage,
    input  cpu_exec_pkg::data_t       src0_data,
    input  cpu_exec_pkg::data_t       src1_data,
    output cpu_exec_pkg::reg_wr_t     alu_wr,
    output cpu_exec_pkg::status_t     status_reg
);

    logic [8:0]            result;   // bit 8 is carry or borrow
    logic                  alu_op;   // stage holds an ALU operation
    logic                  flow_op;  // jump, call or return
    cpu_exec_pkg::status_t flags;

    always_comb begin
        result  = 9'd0;
        alu_op  = 1'b0;
        flow_op = 1'b0;
        case (stage.op)
            cpu_exec_pkg::OP_ADD: begin
                result = {1'b0, src0_data} + {1'b0, src1_data};
                alu_op = 1'b1;
            end
            cpu_exec_pkg::OP_SUB: begin
                result = {1'b0, src0_data} - {1'b0, src1_data}; // msb is the borrow
                alu_op = 1'b1;
            end
            cpu_exec_pkg::OP_OR: begin
                result = {1'b0, src0_data | src1_data};
                alu_op = 1'b1;
            end
            cpu_exec_pkg::OP_AND: begin
                result = {1'b0, src0_data & src1_data};
                alu_op = 1'b1;
            end
            cpu_exec_pkg::OP_XOR: begin
                result = {1'b0, src0_data ^ src1_data};
                alu_op = 1'b1;
            end
            cpu_exec_pkg::OP_JMP,
            cpu_exec_pkg::OP_CALL,
            cpu_exec_pkg::OP_RET: begin
                flow_op = 1'b1;
            end
            default: begin
                result = 9'd0; // nop and memory ops
            end
        endcase
    end

    always_comb begin
        flags.rsvd   = 4'd0;
        flags.z      = (result[7:0] == 8'd0);
        flags.nz     = (result[7:0] != 8'd0);
        flags.st_ovf = 1'b0;
        flags.ovf    = result[8]; // zero for logic ops
    end

    assign alu_wr.en   = stage.valid && alu_op;
    assign alu_wr.sel  = stage.dst_reg;
    assign alu_wr.data = result[7:0];

    // flags visible the cycle after the result
    always_ff @(posedge clk) begin
        if (!reset_) begin
            status_reg <= '0;
        end else if (stage.valid && alu_op) begin
            status_reg <= flags;
        end else if (stage.valid && flow_op) begin
            status_reg <= '0; // flow change clears flags
        end
    end

endmodule

`default_nettype wire

/* common/cpu_exec_pkg.sv */
/*
 * shared types for the execute stage: data, address and register widths,
 * operation and stack sequencer enums, status, stage, memory request and
 * register write structs
 */
`default_nettype none

package cpu_exec_pkg;

    // widths with a meaning of their own
    typedef logic [7:0]  data_t;    // one data byte
    typedef logic [11:0] addr_t;    // data or program address
    typedef logic [1:0]  reg_sel_t; // destination register index

    // operations delivered by decode
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_OR     = 4'd3,
        OP_AND    = 4'd4,
        OP_XOR    = 4'd5,
        OP_MEM_RD = 4'd6,
        OP_MEM_WR = 4'd7,
        OP_JMP    = 4'd8,
        OP_CALL   = 4'd9,
        OP_RET    = 4'd10
    } exec_op_e;

    // two-byte push/pop sequencer
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PUSH_HI = 2'd1,
        ST_PUSH_LO = 2'd2,
        ST_POP_HI  = 2'd3
    } stack_state_e;

    // status register layout, msb first
    typedef struct packed {
        logic [3:0] rsvd;   // always zero
        logic       z;      // result was zero
        logic       nz;     // result was non-zero
        logic       st_ovf; // stack overflow, not generated
        logic       ovf;    // carry or borrow
    } status_t;

    // operation held for one cycle until its operands arrive
    typedef struct packed {
        logic     valid;
        exec_op_e op;
        reg_sel_t dst_reg;
        addr_t    dst_addr;
    } exec_stage_t;

    // data memory request
    typedef struct packed {
        logic  en;
        logic  rd;
        logic  wr;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // register file write
    typedef struct packed {
        logic     en;
        reg_sel_t sel;
        data_t    data;
    } reg_wr_t;

endpackage

`default_nettype wire
